// File: hdl/boxcar_accum.sv
// running window sum for the boxcar filter
// add new sample, subtract delayed one, restart on clear
// emit flag carried alongside the sum

module boxcar_accum (
  // clock and reset
  input  logic                   clk,
  input  logic                   arst_n,

  // controller command for this cycle
  input  boxcar_pkg::accum_cmd_t cmd,

  // new sample and the one leaving the window
  input  boxcar_pkg::sample_t    in_data,
  input  boxcar_pkg::sample_t    old_sample,

  // registered sum and its output flag
  output boxcar_pkg::sum_t       sum,
  output logic                   sum_emit
);

  ////////////////////////////////////////////////////////////////////////////
  // operands
  ////////////////////////////////////////////////////////////////////////////

  // sign extended to sum width
  boxcar_pkg::sum_t new_ext;
  boxcar_pkg::sum_t old_ext;

  assign new_ext = in_data;
  assign old_ext = old_sample;

  ////////////////////////////////////////////////////////////////////////////
  // sum register
  ////////////////////////////////////////////////////////////////////////////

  // intermediate wrap in add then subtract cancels out
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum      <= '0;
      sum_emit <= 1'b0;
    end else begin
      if (cmd.upd) begin
        if (cmd.restart) begin
          sum <= new_ext;
        end else if (cmd.drop_old) begin
          sum <= sum + new_ext - old_ext;
        end else begin
          sum <= sum + new_ext;
        end
      end else if (cmd.restart) begin
        // clear with no sample empties the window
        sum <= '0;
      end
      // one cycle behind the strobe like the sum
      sum_emit <= cmd.emit;
    end
  end

endmodule

// File: hdl/boxcar_ctrl.sv
// window fill tracking FSM for the boxcar filter
// turns sample strobe and clear into accumulator commands
// drives the full level

module boxcar_ctrl (
  // clock and reset
  input  logic                   clk,
  input  logic                   arst_n,

  // sample strobe and restart pulse
  input  logic                   in_valid,
  input  logic                   clear,

  // command to the accumulator, same cycle as the strobe
  output boxcar_pkg::accum_cmd_t cmd,

  // window holds WINDOW samples
  output logic                   full
);

  ////////////////////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////////////////////

  boxcar_pkg::ctrl_state_e state;
  boxcar_pkg::ctrl_state_e state_nxt;

  // accepted samples since the last clear, saturates at WINDOW
  boxcar_pkg::fill_cnt_t   fill_cnt;
  boxcar_pkg::fill_cnt_t   fill_cnt_nxt;

  // this strobe would complete the first window
  logic                    last_fill;

  assign last_fill = (state == boxcar_pkg::FILL) &&
                     (fill_cnt == boxcar_pkg::fill_cnt_t'(boxcar_pkg::WINDOW - 1));

  // next state and count
  always_comb begin
    state_nxt    = state;
    fill_cnt_nxt = fill_cnt;
    if (clear) begin
      // a coinciding strobe is the first sample of the new window
      state_nxt    = boxcar_pkg::FILL;
      fill_cnt_nxt = in_valid ? boxcar_pkg::fill_cnt_t'(1) : '0;
    end else if (in_valid && (state == boxcar_pkg::FILL)) begin
      fill_cnt_nxt = fill_cnt + 1'b1;
      if (last_fill) begin
        state_nxt = boxcar_pkg::RUN;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= boxcar_pkg::FILL;
      fill_cnt <= '0;
    end else begin
      state    <= state_nxt;
      fill_cnt <= fill_cnt_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // commands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd.upd      = in_valid;
    cmd.restart  = clear;
    // delay line output is stale or unreset outside RUN
    cmd.drop_old = in_valid && !clear && (state == boxcar_pkg::RUN);
    // full window after this sample
    cmd.emit     = in_valid && !clear && ((state == boxcar_pkg::RUN) || last_fill);
  end

  // level, rises at the edge of the WINDOW-th strobe
  assign full = (state == boxcar_pkg::RUN);

endmodule

// File: hdl/boxcar_pkg.sv
// shared widths and window constants for the boxcar filter
// sample, sum and fill count types
// controller state encoding and accumulator command struct

package boxcar_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and window
  ////////////////////////////////////////////////////////////////////////////

  // input sample width, two's complement
  localparam int SAMPLE_W    = 12;

  // window is a power of two so the divide is a shift
  localparam int WINDOW_LOG2 = 4;
  localparam int WINDOW      = 1 << WINDOW_LOG2;

  // sum of WINDOW full-scale samples never needs more bits than this
  localparam int SUM_W       = SAMPLE_W + WINDOW_LOG2;

  // fill counter spans 0 to WINDOW inclusive
  localparam int FILL_W      = $clog2(WINDOW + 1);

  // bias added before the shift, round half up
  localparam int ROUND_HALF  = WINDOW / 2;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [SUM_W-1:0]    sum_t;
  typedef logic [FILL_W-1:0]          fill_cnt_t;

  // FILL until WINDOW samples since the last clear, then RUN
  typedef enum logic {
    FILL = 1'b0,
    RUN  = 1'b1
  } ctrl_state_e;

  // per-sample command from controller to accumulator
  typedef struct packed {
    logic upd;       // apply this sample
    logic restart;   // clear the sum before adding
    logic drop_old;  // subtract the delayed sample
    logic emit;      // this sample produces an output
  } accum_cmd_t;

endpackage

// File: hdl/boxcar_round.sv
// divide the window sum by WINDOW, round half up
// registered average and output strobe

module boxcar_round (
  // clock and reset
  input  logic                clk,
  input  logic                arst_n,

  // window sum and its output flag
  input  boxcar_pkg::sum_t    sum,
  input  logic                sum_emit,

  // rounded average, strobe for one cycle
  output boxcar_pkg::sample_t out_avg,
  output logic                out_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // rounding
  ////////////////////////////////////////////////////////////////////////////

  // max sum plus the bias still fits, no extra bit
  boxcar_pkg::sum_t biased;
  boxcar_pkg::sum_t shifted;

  assign biased  = sum + boxcar_pkg::sum_t'(boxcar_pkg::ROUND_HALF);
  // arithmetic shift keeps the sign, rounds toward +inf on a tie
  assign shifted = biased >>> boxcar_pkg::WINDOW_LOG2;

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  // average held between outputs
  always_ff @(posedge clk) begin
    if (sum_emit) begin
      out_avg <= shifted[boxcar_pkg::SAMPLE_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_emit;
    end
  end

endmodule

// File: hdl/boxcar_top.sv
// boxcar moving-average filter top level
// controller, delay line, running sum and rounding stage

module boxcar_top (
  // clock and reset
  input  logic                clk,
  input  logic                arst_n,

  // sample stream in
  input  logic                in_valid,
  input  boxcar_pkg::sample_t in_data,
  input  logic                clear,

  // averages out
  output logic                out_valid,
  output boxcar_pkg::sample_t out_avg,
  output logic                full
);

  ////////////////////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////////////////////

  boxcar_pkg::accum_cmd_t cmd;
  boxcar_pkg::sample_t    old_sample;
  boxcar_pkg::sum_t       sum;
  logic                   sum_emit;

  // fill tracking and command decode
  boxcar_ctrl u_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .clear    (clear),
    .cmd      (cmd),
    .full     (full)
  );

  // sample from WINDOW strobes back, advances on every strobe
  shift_reg #(
    .WIDTH (boxcar_pkg::SAMPLE_W),
    .DEPTH (boxcar_pkg::WINDOW - 1)
  ) u_delay (
    .clk  (clk),
    .ena  (in_valid),
    .din  (in_data),
    .dout (old_sample)
  );

  // running sum, one cycle after the strobe
  boxcar_accum u_accum (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd        (cmd),
    .in_data    (in_data),
    .old_sample (old_sample),
    .sum        (sum),
    .sum_emit   (sum_emit)
  );

  // average, two cycles after the strobe
  boxcar_round u_round (
    .clk       (clk),
    .arst_n    (arst_n),
    .sum       (sum),
    .sum_emit  (sum_emit),
    .out_avg   (out_avg),
    .out_valid (out_valid)
  );

endmodule

// File: hdl/shift_reg.sv
// enabled delay line, DEPTH+1 register stages
// no reset, output taken straight from the last stage

module shift_reg #(
  // data width
  parameter int WIDTH = 1,
  // extra stages, 0 gives a single register
  parameter int DEPTH = 7
) (
  // clock and enable
  input  logic             clk,
  input  logic             ena,

  // data in and delayed data out
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // stage 0 takes din, stage DEPTH drives dout
  logic [WIDTH-1:0] stage [DEPTH+1];

  // contents are unknown until DEPTH+1 enabled edges have passed
  always_ff @(posedge clk) begin
    if (ena) begin
      stage[0] <= din;
      // move every stage one step along
      for (int i = 1; i <= DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output
  ////////////////////////////////////////////////////////////////////////////

  // registered, no logic after the last flop
  assign dout = stage[DEPTH];

  // with ena high at an edge, dout then holds the word
  // that entered DEPTH+1 enabled edges earlier
  // so in a strobe cycle it shows the sample from
  // DEPTH+1 strobes before the current one

endmodule

// File: run.sh
#!/bin/sh
# build and run the boxcar testbench with Verilator
# exits non-zero on a build error, a simulator error or a failing run

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module boxcar_tb -Mdir "$OBJ" -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vboxcar_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "result: fail"
  exit 1
fi

echo "result: pass"
exit 0

// File: sim.f
hdl/boxcar_pkg.sv
hdl/shift_reg.sv
hdl/boxcar_ctrl.sv
hdl/boxcar_accum.sv
hdl/boxcar_round.sv
hdl/boxcar_top.sv
verif/boxcar_properties.sv
verif/boxcar_tb.sv

// File: verif/boxcar_properties.sv
// concurrent checks on the boxcar top-level strobes
// output latency, full window behind each output, quiet during reset
// bound into boxcar_top

module boxcar_properties (
  input logic clk,
  input logic arst_n,
  input logic in_valid,
  input logic out_valid,
  input logic full
);

  ////////////////////////////////////////////////////////////////////////////
  // strobe timing
  ////////////////////////////////////////////////////////////////////////////

  // every output goes back to a sample strobe two cycles earlier
  a_out_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> $past(in_valid, 2)
  ) else $error("out_valid without in_valid two cycles earlier");

  // window was complete after the strobe
  // a clear in between may already have dropped full
  a_out_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> (full || $past(full))
  ) else $error("out_valid while the window was never full");

  ////////////////////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (
    @(posedge clk)
    !arst_n |-> (!out_valid && !full)
  ) else $error("out_valid or full high during reset");

endmodule

bind boxcar_top boxcar_properties u_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .full      (full)
);

// File: verif/boxcar_tb.sv
// boxcar filter testbench, clock, reset and random stimulus from a fixed seed
// queue-based reference model with an expected-average FIFO
// fill, random stream, clear, extreme value and latency tests

module boxcar_tb;

  localparam int S_MAX = (1 << (boxcar_pkg::SAMPLE_W - 1)) - 1;
  localparam int S_MIN = -(1 << (boxcar_pkg::SAMPLE_W - 1));

  logic                clk;
  logic                arst_n;
  logic                in_valid;
  boxcar_pkg::sample_t in_data;
  logic                clear;
  logic                out_valid;
  boxcar_pkg::sample_t out_avg;
  logic                full;

  // model state, samples since the last clear, oldest first
  int win_q[$];
  // expected averages and the edge at which each is due
  int avg_q[$];
  int due_q[$];

  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int out_count = 0;
  int last_avg = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int err0;

  boxcar_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .clear     (clear),
    .out_valid (out_valid),
    .out_avg   (out_avg),
    .full      (full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and output checks, sampled at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  // rounded mean of the model window, half rounds toward +inf
  function automatic int window_avg();
    int s;
    s = 0;
    foreach (win_q[i]) s += win_q[i];
    return (s + boxcar_pkg::WINDOW / 2) >>> boxcar_pkg::WINDOW_LOG2;
  endfunction

  always @(posedge clk) begin : model_check
    int exp_avg;
    logic exp_full;
    cyc = cyc + 1;
    if (arst_n) begin
      // full follows the window as it stood after the previous edge
      exp_full = (win_q.size() == boxcar_pkg::WINDOW);
      if (full !== exp_full) begin
        $display("FAIL t=%0t full got %b expected %b", $time, full, exp_full);
        errors++;
      end
      // anything overdue never showed up
      while (due_q.size() > 0 && due_q[0] < cyc) begin
        $display("missing out_valid at time %0t, average %0d never came out",
                 $time, avg_q[0]);
        errors++;
        void'(due_q.pop_front());
        void'(avg_q.pop_front());
      end
      if (out_valid === 1'b1) begin
        out_count++;
        last_avg = int'(out_avg);
        if (due_q.size() == 0 || due_q[0] != cyc) begin
          $display("unexpected out_valid at time %0t with no average due", $time);
          errors++;
        end else begin
          exp_avg = avg_q.pop_front();
          void'(due_q.pop_front());
          checks++;
          if (int'(out_avg) != exp_avg) begin
            $display("FAIL t=%0t out_avg got %0d expected %0d",
                     $time, int'(out_avg), exp_avg);
            errors++;
          end
        end
      end else if (out_valid !== 1'b0) begin
        $display("out_valid is unknown at time %0t", $time);
        errors++;
      end
      // window update for the strobe of the cycle that just ended
      if (in_valid) begin
        if (clear) win_q.delete();
        win_q.push_back(int'(in_data));
        if (win_q.size() > boxcar_pkg::WINDOW) void'(win_q.pop_front());
        // two edges from here to the output register
        if (win_q.size() == boxcar_pkg::WINDOW) begin
          avg_q.push_back(window_avg());
          due_q.push_back(cyc + 2);
        end
      end else if (clear) begin
        win_q.delete();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic boxcar_pkg::sample_t rand_sample();
    logic [31:0] r;
    r = $urandom;
    return r[boxcar_pkg::SAMPLE_W-1:0];
  endfunction

  task automatic drive(input logic v, input int d, input logic c);
    @(posedge clk);
    in_valid <= v;
    in_data  <= boxcar_pkg::sample_t'(d);
    clear    <= c;
  endtask

  // data keeps changing so a sample taken without a strobe shows up
  task automatic idle(input int n);
    repeat (n) drive(1'b0, int'(rand_sample()), 1'b0);
  endtask

  task automatic wait_outputs(input int target, input int limit);
    for (int n = 0; n < limit; n++) begin
      @(negedge clk);
      if (out_count >= target) break;
    end
    if (out_count < target) begin
      $display("timed out after %0d cycles waiting for out_valid", limit);
      errors++;
    end
  endtask

  task automatic drain(input int limit);
    idle(1);
    for (int n = 0; n < limit; n++) begin
      @(negedge clk);
      if (due_q.size() == 0) break;
    end
    if (due_q.size() != 0) begin
      $display("timed out after %0d cycles with %0d averages still due",
               limit, due_q.size());
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    @(negedge clk);
    if (got != exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_fill();
    int base;
    base = out_count;
    for (int i = 0; i < boxcar_pkg::WINDOW - 1; i++) drive(1'b1, int'(rand_sample()), 1'b0);
    idle(4);
    check_count(out_count, base, "outputs before window full");
    if (full !== 1'b0) begin
      $display("FAIL t=%0t full got %b expected 0", $time, full);
      errors++;
    end
    // WINDOW-th strobe completes the window
    drive(1'b1, int'(rand_sample()), 1'b0);
    idle(1);
    wait_outputs(base + 1, 10);
    if (full !== 1'b1) begin
      $display("FAIL t=%0t full got %b expected 1", $time, full);
      errors++;
    end
    drain(10);
  endtask

  task automatic test_random(input int strobes);
    int gap;
    for (int i = 0; i < strobes; i++) begin
      gap = ($urandom % 3 == 0) ? $urandom_range(1, 4) : 0;
      if (gap > 0) idle(gap);
      drive(1'b1, int'(rand_sample()), 1'b0);
    end
    drain(20);
  endtask

  task automatic test_clear();
    int base;
    int r;
    // clear alone, then a full refill before the next output
    drain(20);
    base = out_count;
    drive(1'b0, int'(rand_sample()), 1'b1);
    for (int i = 0; i < boxcar_pkg::WINDOW - 1; i++) drive(1'b1, int'(rand_sample()), 1'b0);
    drain(20);
    check_count(out_count, base, "outputs after clear");
    drive(1'b1, int'(rand_sample()), 1'b0);
    drain(20);
    check_count(out_count, base + 1, "outputs after refill");
    // clear with a strobe, that sample opens the new window
    drive(1'b1, int'(rand_sample()), 1'b1);
    for (int i = 0; i < boxcar_pkg::WINDOW - 2; i++) drive(1'b1, int'(rand_sample()), 1'b0);
    drain(20);
    check_count(out_count, base + 1, "outputs after clear with strobe");
    drive(1'b1, int'(rand_sample()), 1'b0);
    drain(20);
    check_count(out_count, base + 2, "outputs after refill with strobe");
    // random stream with occasional clears of both kinds
    for (int i = 0; i < 400; i++) begin
      r = $urandom % 32;
      if ($urandom % 4 == 0) idle($urandom_range(1, 3));
      if (r == 0) drive(1'b0, int'(rand_sample()), 1'b1);
      else if (r == 1) drive(1'b1, int'(rand_sample()), 1'b1);
      else drive(1'b1, int'(rand_sample()), 1'b0);
    end
    drain(20);
  endtask

  // one full window of a value pattern, then the last average against exp
  task automatic extreme_window(input int a, input int b, input int exp);
    drive(1'b0, 0, 1'b1);
    for (int i = 0; i < boxcar_pkg::WINDOW; i++) drive(1'b1, (i % 2 == 0) ? a : b, 1'b0);
    drain(20);
    check_count(last_avg, exp, "out_avg");
  endtask

  task automatic test_extremes();
    extreme_window(S_MAX, S_MAX, S_MAX);
    extreme_window(S_MIN, S_MIN, S_MIN);
    // eight of each sum to -8, the bias brings it to exactly zero
    extreme_window(S_MAX, S_MIN, 0);
  endtask

  task automatic test_latency();
    int base;
    drain(20);
    base = out_count;
    // window is full, so every strobe here gives an output
    for (int i = 0; i < 40; i++) drive(1'b1, int'(rand_sample()), 1'b0);
    for (int i = 0; i < 20; i++) begin
      idle(i % 3);
      drive(1'b1, int'(rand_sample()), 1'b0);
    end
    drain(20);
    check_count(out_count - base, 60, "outputs in latency burst");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h40a81ad3));
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    clear    = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    err0 = errors;
    test_fill();
    report_test("fill", err0);
    err0 = errors;
    test_random(2000);
    report_test("random", err0);
    err0 = errors;
    test_clear();
    report_test("clear", err0);
    err0 = errors;
    test_extremes();
    report_test("extremes", err0);
    err0 = errors;
    test_latency();
    report_test("latency", err0);

    $display("summary: %0d tests, %0d failed, %0d averages checked, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // run limit, well past the longest expected sequence
  initial begin
    repeat (100000) @(posedge clk);
    $display("simulation ran past its cycle limit");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
